// File: src.f
+incdir+verif
design/lc3Pkg.sv
design/memRegs.sv
design/pcUnit.sv
design/addressUnit.sv
design/regFile.sv
design/alu.sv
design/branchEnable.sv
design/datapath.sv
verif/tbDatapath.sv

// File: verif/lc3Model.svh
// architectural state of the reference model
typedef struct packed {
	word               pc;
	word               mar;
	word               mdr;
	word               ir;
	word [numRegs-1:0] regs;
	nzp                cc;
	logic              ben;
} archState;

function automatic word signExtend(input word value, input int width);
	word result;
	result = value;
	for (int i = width; i < 16; i++)
		result[i] = value[width - 1];
	return result;
endfunction

// SR1 is IR[11:9] or IR[8:6]
function automatic word sourceOne(input archState s, input ctrlWord c);
	return c.sr1Mux ? s.regs[s.ir[11:9]] : s.regs[s.ir[8:6]];
endfunction

function automatic word aluResult(input archState s, input ctrlWord c);
	word a;
	word b;
	word result;
	a = sourceOne(s, c);
	b = c.sr2Mux ? signExtend(s.ir, 5) : s.regs[s.ir[2:0]];
	case (c.aluK)
		aluAdd:  result = a + b;
		aluAnd:  result = a & b;
		aluNot:  result = ~a;
		default: result = a;
	endcase
	return result;
endfunction

function automatic word addrResult(input archState s, input ctrlWord c);
	word base;
	word offset;
	base = c.addr1Mux ? sourceOne(s, c) : s.pc;
	case (c.addr2Mux)
		offSext6:  offset = signExtend(s.ir, 6);
		offSext9:  offset = signExtend(s.ir, 9);
		offSext11: offset = signExtend(s.ir, 11);
		default:   offset = '0;
	endcase
	return base + offset;
endfunction

// MDR wins, then ALU, PC and the address adder
function automatic word busValue(input archState s, input ctrlWord c);
	if (c.gateMdr)
		return s.mdr;
	if (c.gateAlu)
		return aluResult(s, c);
	if (c.gatePc)
		return s.pc;
	if (c.gateMarMux)
		return addrResult(s, c);
	return '0;
endfunction

function automatic nzp signCode(input word value);
	if (value[15])
		return 3'b100;
	if (value == '0)
		return 3'b010;
	return 3'b001;
endfunction

// state after one clock edge with control word c
function automatic archState stepModel(input archState s, input ctrlWord c, input word mem);
	archState n;
	word bus;
	n = s;
	bus = busValue(s, c);
	if (c.ldMar)
		n.mar = bus;
	if (c.ldMdr)
		n.mdr = c.mioEn ? mem : bus;
	if (c.ldIr)
		n.ir = bus;
	if (c.ldPc) begin
		case (c.pcMux)
			pcInc:   n.pc = s.pc + 16'd1;
			pcBus:   n.pc = bus;
			pcAddr:  n.pc = addrResult(s, c);
			default: n.pc = s.pc;
		endcase
	end
	if (c.ldReg)
		n.regs[c.drMux ? 3'd7 : s.ir[11:9]] = bus;
	if (c.ldCc)
		n.cc = signCode(bus);
	// BEN uses the CC held before this edge
	if (c.ldBen)
		n.ben = |(s.ir[11:9] & s.cc);
	return n;
endfunction

// File: verif/tbDatapath.sv
`timescale 1ns/1ps
`default_nettype none

module tbDatapath
	import lc3Pkg::*;
();

	localparam int numInstr = 200;
	localparam int maxInstrCycles = 8;
	localparam int timeoutCycles = numInstr * maxInstrCycles * 5 / 4;
	localparam int numTests = 170;

	logic    Clk;
	logic    reset;
	ctrlWord ctrl;
	word     mdrIn;
	word     mar;
	word     mdr;
	word     ir;
	word     pc;
	logic    ir5;
	logic    ir11;
	logic    ben;
	int      cycles = 0;

	`include "lc3Model.svh"

	archState expected;
	archState pending;

	datapath datapath_inst (.*);

	initial begin
		Clk = 1'b0;
		forever #20 Clk = ~Clk;
	end

	always @(posedge Clk) begin
		cycles++;
		if (cycles >= timeoutCycles) begin
			$display("timeout after %0d cycles, the test sequence did not finish", cycles);
			$display("Done: errors found");
			$fatal(1);
		end
	end

	task automatic checkWord(input string name, input word actual, input word exp);
		if (actual !== exp) begin
			$display("FAILED %s: expected %h, got %h", name, exp, actual);
			$display("Done: errors found");
			$fatal(1);
		end
	endtask

	task automatic checkBit(input string name, input logic actual, input logic exp);
		if (actual !== exp) begin
			$display("FAILED %s: expected %h, got %h", name, exp, actual);
			$display("Done: errors found");
			$fatal(1);
		end
	endtask

	// outputs are settled half a cycle after the edge
	always @(negedge Clk) begin
		if (!reset) begin
			checkWord("mar", mar, expected.mar);
			checkWord("mdr", mdr, expected.mdr);
			checkWord("ir", ir, expected.ir);
			checkWord("pc", pc, expected.pc);
			checkBit("ir5", ir5, expected.ir[5]);
			checkBit("ir11", ir11, expected.ir[11]);
			checkBit("ben", ben, expected.ben);
		end
	end

	// one control cycle driven 2 ns after the edge
	task automatic runCycle(input ctrlWord c, input word data);
		ctrl = c;
		mdrIn = data;
		pending = stepModel(expected, c, data);
		@(posedge Clk);
		expected = pending;
		#2;
	endtask

	task automatic memRead(input word data);
		ctrlWord c;
		c = '0;
		c.ldMdr = 1'b1;
		c.mioEn = 1'b1;
		runCycle(c, data);
	endtask

	task automatic fetch(input word instr);
		ctrlWord c;
		c = '0;
		c.gatePc = 1'b1;
		c.ldMar = 1'b1;
		c.ldPc = 1'b1;
		c.pcMux = pcInc;
		runCycle(c, '0);
		memRead(instr);
		c = '0;
		c.gateMdr = 1'b1;
		c.ldIr = 1'b1;
		runCycle(c, '0);
	endtask

	// pass the IR[11:9] register through the ALU into MAR
	task automatic readBack();
		ctrlWord c;
		c = '0;
		c.gateAlu = 1'b1;
		c.aluK = aluPass;
		c.sr1Mux = 1'b1;
		c.ldMar = 1'b1;
		runCycle(c, '0);
	endtask

	task automatic aluInstr();
		ctrlWord c;
		word instr;
		int kind;
		kind = $urandom_range(2);
		instr = word'($urandom);
		case (kind)
			0: instr[15:12] = 4'b0001;
			1: instr[15:12] = 4'b0101;
			default: instr = {4'b1001, instr[11:6], 6'b111111};
		endcase
		fetch(instr);
		c = '0;
		c.gateAlu = 1'b1;
		c.aluK = (kind == 0) ? aluAdd : (kind == 1) ? aluAnd : aluNot;
		c.sr2Mux = instr[5];
		c.ldReg = 1'b1;
		c.ldCc = 1'b1;
		runCycle(c, '0);
		readBack();
	endtask

	// LD when baseForm is low and LDR when it is high
	task automatic loadInstr(input regIdx dr, input logic baseForm);
		ctrlWord c;
		word instr;
		instr = word'($urandom);
		instr[15:9] = {baseForm ? 4'b0110 : 4'b0010, dr};
		fetch(instr);
		c = '0;
		c.gateMarMux = 1'b1;
		c.addr1Mux = baseForm;
		c.addr2Mux = baseForm ? offSext6 : offSext9;
		c.ldMar = 1'b1;
		runCycle(c, '0);
		memRead(word'($urandom));
		c = '0;
		c.gateMdr = 1'b1;
		c.ldReg = 1'b1;
		c.ldCc = 1'b1;
		runCycle(c, '0);
		readBack();
	endtask

	task automatic branchInstr();
		ctrlWord c;
		fetch({4'b0000, 12'($urandom)});
		c = '0;
		c.ldBen = 1'b1;
		runCycle(c, '0);
		// taken branch
		if (expected.ben) begin
			c = '0;
			c.ldPc = 1'b1;
			c.pcMux = pcAddr;
			c.addr2Mux = offSext9;
			runCycle(c, '0);
		end
	endtask

	// JSR saves PC in R7 first
	// JMP takes its base from IR[8:6]
	task automatic jumpInstr(input logic link);
		ctrlWord c;
		fetch(link ? {5'b01001, 11'($urandom)} : {7'b1100000, 3'($urandom), 6'b0});
		if (link) begin
			c = '0;
			c.gatePc = 1'b1;
			c.drMux = 1'b1;
			c.ldReg = 1'b1;
			runCycle(c, '0);
		end
		c = '0;
		c.ldPc = 1'b1;
		c.pcMux = pcAddr;
		c.addr1Mux = !link;
		c.addr2Mux = link ? offSext11 : offZero;
		runCycle(c, '0);
	endtask

	// store value from one gated source and then PC loaded from MDR
	task automatic storeInstr(input regIdx sr, input int gate);
		ctrlWord c;
		fetch({4'b0011, sr, 9'($urandom)});
		c = '0;
		c.gateMarMux = 1'b1;
		c.addr2Mux = offSext9;
		c.ldMar = 1'b1;
		runCycle(c, '0);
		c = '0;
		c.ldMdr = 1'b1;
		c.addr2Mux = offSext9;
		c.aluK = aluPass;
		c.sr1Mux = 1'b1;
		case (gate)
			0: c.gateAlu = 1'b1;
			1: c.gatePc = 1'b1;
			default: c.gateMarMux = 1'b1;
		endcase
		// memory data present but must be ignored
		runCycle(c, word'($urandom));
		c = '0;
		c.gateMdr = 1'b1;
		c.ldPc = 1'b1;
		c.pcMux = pcBus;
		runCycle(c, '0);
	endtask

	initial begin
		int kind;
		void'($urandom(32'hba5e_bc83));
		reset = 1'b1;
		ctrl = '0;
		mdrIn = '0;
		expected = '0;
		pending = '0;
		repeat (2) @(posedge Clk);
		#2;
		reset = 1'b0;
		for (int r = 0; r < numRegs; r++)
			loadInstr(regIdx'(r), 1'b0);
		for (int i = 0; i < numTests; i++) begin
			kind = $urandom_range(5);
			case (kind)
				0: aluInstr();
				1: loadInstr(regIdx'($urandom), 1'b1);
				2: branchInstr();
				3: jumpInstr(1'b0);
				4: begin
					jumpInstr(1'b1);
					storeInstr(3'd7, 0);
				end
				default: storeInstr(regIdx'($urandom), $urandom_range(2));
			endcase
		end
		runCycle('0, '0);
		@(negedge Clk);
		#1;
		$display("Done: no errors");
		$finish;
	end

endmodule

`default_nettype wire

// File: design/datapath.sv
`timescale 1ns/1ps
`default_nettype none

module datapath
	import lc3Pkg::*;
(
	input  logic    Clk,
	input  logic    reset,
	input  ctrlWord ctrl,
	input  word     mdrIn,
	output word     mar,
	output word     mdr,
	output word     ir,
	output word     pc,
	output logic    ir5,
	output logic    ir11,
	output logic    ben
);

	word bus;
	word addrSum;
	word sr1Out;
	word sr2Out;
	word aluOut;

	// shared bus with MDR at the highest priority
	always_comb begin
		if (ctrl.gateMdr)
			bus = mdr;
		else if (ctrl.gateAlu)
			bus = aluOut;
		else if (ctrl.gatePc)
			bus = pc;
		else if (ctrl.gateMarMux)
			bus = addrSum;
		else
			bus = '0;
	end

	memRegs memRegs_inst (
		.Clk   (Clk),
		.reset (reset),
		.ldMar (ctrl.ldMar),
		.ldMdr (ctrl.ldMdr),
		.ldIr  (ctrl.ldIr),
		.mioEn (ctrl.mioEn),
		.bus   (bus),
		.mdrIn (mdrIn),
		.mar   (mar),
		.mdr   (mdr),
		.ir    (ir)
	);

	pcUnit pcUnit_inst (
		.Clk     (Clk),
		.reset   (reset),
		.ldPc    (ctrl.ldPc),
		.pcMux   (ctrl.pcMux),
		.bus     (bus),
		.addrSum (addrSum),
		.pc      (pc)
	);

	addressUnit addressUnit_inst (
		.ir       (ir),
		.pc       (pc),
		.sr1Out   (sr1Out),
		.addr1Mux (ctrl.addr1Mux),
		.addr2Mux (ctrl.addr2Mux),
		.addrSum  (addrSum)
	);

	regFile regFile_inst (
		.Clk    (Clk),
		.reset  (reset),
		.ldReg  (ctrl.ldReg),
		.drMux  (ctrl.drMux),
		.sr1Mux (ctrl.sr1Mux),
		.ir     (ir),
		.bus    (bus),
		.sr1Out (sr1Out),
		.sr2Out (sr2Out)
	);

	alu alu_inst (
		.sr1Out (sr1Out),
		.sr2Out (sr2Out),
		.ir     (ir),
		.sr2Mux (ctrl.sr2Mux),
		.aluK   (ctrl.aluK),
		.aluOut (aluOut)
	);

	branchEnable branchEnable_inst (
		.Clk   (Clk),
		.reset (reset),
		.ldCc  (ctrl.ldCc),
		.ldBen (ctrl.ldBen),
		.bus   (bus),
		.ir    (ir),
		.ben   (ben)
	);

	// status bits the sequencer decodes on
	assign ir5  = ir[5];
	assign ir11 = ir[11];

	// a second active gate would be hidden by the priority mux
	oneGate: assert property (@(posedge Clk) disable iff (reset)
		$onehot0({ctrl.gateMdr, ctrl.gateAlu, ctrl.gatePc, ctrl.gateMarMux}));

endmodule

`default_nettype wire

// File: design/branchEnable.sv
`timescale 1ns/1ps
`default_nettype none

module branchEnable
	import lc3Pkg::*;
(
	input  logic Clk,
	input  logic reset,
	input  logic ldCc,
	input  logic ldBen,
	input  word  bus,
	input  word  ir,
	output logic ben
);

	nzp cc;
	nzp ccNext;
	nzp ccMatch;

	// sign of the bus value as N, Z, P
	always_comb begin
		if (bus[15])
			ccNext = 3'b100;
		else if (bus == '0)
			ccNext = 3'b010;
		else
			ccNext = 3'b001;
	end

	// IR[11:9] holds the n, z, p request bits of a BR
	assign ccMatch = ir[11:9] & cc;

	always_ff @(posedge Clk) begin
		if (reset) begin
			cc  <= '0;
			ben <= 1'b0;
		end else begin
			if (ldCc)
				cc <= ccNext;
			if (ldBen)
				ben <= |ccMatch;
		end
	end

endmodule

`default_nettype wire

// File: design/alu.sv
`timescale 1ns/1ps
`default_nettype none

module alu
	import lc3Pkg::*;
(
	input  word  sr1Out,
	input  word  sr2Out,
	input  word  ir,
	input  logic sr2Mux,
	input  aluOp aluK,
	output word  aluOut
);

	word imm5;
	word opB;

	// immediate form when IR[5] is set
	assign imm5 = {{11{ir[4]}}, ir[4:0]};
	assign opB  = sr2Mux ? imm5 : sr2Out;

	always_comb begin
		case (aluK)
			aluAdd:  aluOut = sr1Out + opB;
			aluAnd:  aluOut = sr1Out & opB;
			aluNot:  aluOut = ~sr1Out;
			// pass is how a register reaches the bus
			aluPass: aluOut = sr1Out;
			default: aluOut = sr1Out;
		endcase
	end

endmodule

`default_nettype wire

// File: design/regFile.sv
`timescale 1ns/1ps
`default_nettype none

module regFile
	import lc3Pkg::*;
(
	input  logic Clk,
	input  logic reset,
	input  logic ldReg,
	input  logic drMux,
	input  logic sr1Mux,
	input  word  ir,
	input  word  bus,
	output word  sr1Out,
	output word  sr2Out
);

	word   regs [numRegs];
	regIdx dr;
	regIdx sr1;
	regIdx sr2;

	// destination is R7 for link saves
	assign dr = drMux ? linkReg : ir[11:9];

	// sr1Mux high picks IR[11:9] so stores can read their source register
	assign sr1 = sr1Mux ? ir[11:9] : ir[8:6];

	// SR2 field is fixed
	assign sr2 = ir[2:0];

	always_ff @(posedge Clk) begin
		if (reset) begin
			for (int i = 0; i < numRegs; i++) begin
				regs[i] <= '0;
			end
		end else if (ldReg) begin
			regs[dr] <= bus;
		end
	end

	// asynchronous reads
	assign sr1Out = regs[sr1];
	assign sr2Out = regs[sr2];

endmodule

`default_nettype wire

// File: design/addressUnit.sv
`timescale 1ns/1ps
`default_nettype none

module addressUnit
	import lc3Pkg::*;
(
	input  word     ir,
	input  word     pc,
	input  word     sr1Out,
	input  logic    addr1Mux,
	input  addr2Sel addr2Mux,
	output word     addrSum
);

	word base;
	word offset;
	word off6;
	word off9;
	word off11;

	// base is PC for PC-relative forms and SR1 for base+offset forms
	assign base = addr1Mux ? sr1Out : pc;

	// offset6 for LDR/STR, PCoffset9 for LD/ST/BR, PCoffset11 for JSR
	assign off6  = {{10{ir[5]}}, ir[5:0]};
	assign off9  = {{7{ir[8]}}, ir[8:0]};
	assign off11 = {{5{ir[10]}}, ir[10:0]};

	always_comb begin
		case (addr2Mux)
			offZero:   offset = '0;
			offSext6:  offset = off6;
			offSext9:  offset = off9;
			offSext11: offset = off11;
			default:   offset = '0;
		endcase
	end

	// wraps at 16 bits like the address space
	assign addrSum = base + offset;

endmodule

`default_nettype wire

// File: design/pcUnit.sv
`timescale 1ns/1ps
`default_nettype none

module pcUnit
	import lc3Pkg::*;
(
	input  logic Clk,
	input  logic reset,
	input  logic ldPc,
	input  pcSel pcMux,
	input  word  bus,
	input  word  addrSum,
	output word  pc
);

	word pcNext;

	// next-PC select
	always_comb begin
		case (pcMux)
			pcInc:   pcNext = pc + 16'd1;
			pcBus:   pcNext = bus;
			pcAddr:  pcNext = addrSum;
			// unused code holds the current PC
			default: pcNext = pc;
		endcase
	end

	always_ff @(posedge Clk) begin
		if (reset)
			pc <= '0;
		else if (ldPc)
			pc <= pcNext;
	end

	validPcSel: assert property (@(posedge Clk) disable iff (reset)
		ldPc |-> (pcMux != 2'd3));

endmodule

`default_nettype wire

// File: design/memRegs.sv
`timescale 1ns/1ps
`default_nettype none

module memRegs
	import lc3Pkg::*;
(
	input  logic Clk,
	input  logic reset,
	input  logic ldMar,
	input  logic ldMdr,
	input  logic ldIr,
	input  logic mioEn,
	input  word  bus,
	input  word  mdrIn,
	output word  mar,
	output word  mdr,
	output word  ir
);

	word mdrNext;

	// memory read data or a store value from the bus
	assign mdrNext = mioEn ? mdrIn : bus;

	always_ff @(posedge Clk) begin
		if (reset) begin
			mar <= '0;
			mdr <= '0;
			ir  <= '0;
		end else begin
			if (ldMar)
				mar <= bus;
			if (ldMdr)
				mdr <= mdrNext;
			// IR is fed from the bus, normally with MDR gated on
			if (ldIr)
				ir <= bus;
		end
	end

	// IR needs the MDR value of the previous cycle, never the one being loaded
	noIrMdrOverlap: assert property (@(posedge Clk) disable iff (reset)
		!(ldIr && ldMdr));

endmodule

`default_nettype wire

// File: design/lc3Pkg.sv
`default_nettype none

package lc3Pkg;

	// datapath word and field widths
	typedef logic [15:0] word;
	typedef logic [2:0]  regIdx;
	typedef logic [2:0]  nzp;
	typedef logic [1:0]  aluOp;
	typedef logic [1:0]  pcSel;
	typedef logic [1:0]  addr2Sel;

	// register file depth and the link register used by JSR/TRAP style saves
	localparam int    numRegs = 8;
	localparam regIdx linkReg = 3'd7;

	// ALU function codes
	localparam aluOp aluAdd  = 2'd0;
	localparam aluOp aluAnd  = 2'd1;
	localparam aluOp aluNot  = 2'd2;
	localparam aluOp aluPass = 2'd3;

	// next-PC source with code 3 unused
	localparam pcSel pcInc  = 2'd0;
	localparam pcSel pcBus  = 2'd1;
	localparam pcSel pcAddr = 2'd2;

	// address adder offset taken from IR
	localparam addr2Sel offZero   = 2'd0;
	localparam addr2Sel offSext6  = 2'd1;
	localparam addr2Sel offSext9  = 2'd2;
	localparam addr2Sel offSext11 = 2'd3;

	// one cycle of control from the sequencer
	typedef struct packed {
		logic    ldMar;
		logic    ldMdr;
		logic    ldIr;
		logic    ldBen;
		logic    ldCc;
		logic    ldReg;
		logic    ldPc;
		logic    gatePc;
		logic    gateMdr;
		logic    gateAlu;
		logic    gateMarMux;
		pcSel    pcMux;
		addr2Sel addr2Mux;
		aluOp    aluK;
		// drMux high selects R7
		// sr1Mux high selects IR[11:9]
		logic    drMux;
		logic    sr1Mux;
		// sr2Mux high selects imm5
		// addr1Mux high selects SR1 as base
		logic    sr2Mux;
		logic    addr1Mux;
		logic    mioEn;
	} ctrlWord;

endpackage

`default_nettype wire
